//--- rtl/fe_pkg.sv
`default_nettype none

package fe_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [1:0]  slot_mask_t;

  localparam int FIFO_DEPTH    = 8;
  localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
  localparam int FETCH_CREDITS = 2;

  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;

  // opcodes sized to the slice they are compared against
  localparam logic [16:0] OPC_ADD_W   = 17'h00020;
  localparam logic [16:0] OPC_SUB_W   = 17'h00022;
  localparam logic [16:0] OPC_AND     = 17'h00029;
  localparam logic [16:0] OPC_OR      = 17'h0002a;
  localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;
  localparam logic [9:0]  OPC_ORI     = 10'h00e;
  localparam logic [9:0]  OPC_LD_W    = 10'h0a2;
  localparam logic [9:0]  OPC_ST_W    = 10'h0a6;
  localparam logic [6:0]  OPC_LU12I_W = 7'h0a;
  localparam logic [5:0]  OPC_JIRL    = 6'h13;
  localparam logic [5:0]  OPC_BL      = 6'h15;
  localparam logic [5:0]  OPC_BEQ     = 6'h16;
  localparam logic [5:0]  OPC_BNE     = 6'h17;

  typedef enum logic [3:0] {
    OP_ALU3R,
    OP_ALU2RI,
    OP_LU12I,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_JIRL,
    OP_BL,
    OP_INVALID
  } op_class_e;

  typedef enum logic [1:0] {R0_NONE, R0_RK, R0_RD} r0_sel_e;
  typedef enum logic       {R1_NONE, R1_RJ} r1_sel_e;
  typedef enum logic [1:0] {W_NONE, W_RD, W_BL1} w_sel_e;

  typedef struct packed {
    reg_idx_t rs0;
    reg_idx_t rs1;
    reg_idx_t rd;
  } reg_info_t;

  typedef struct packed {
    addr_t     pc;
    op_class_e op;
    reg_info_t ri;
    logic      ine;
  } slot_t;

  typedef struct packed {
    slot_t [1:0] slot;
    slot_mask_t  mask;
  } pair_t;

endpackage

`default_nettype wire

//--- rtl/fe_if.sv
`timescale 1ns/1ps
`default_nettype none

// pc generator to fetch
interface fe_pc_if;
  logic               valid;
  logic               ready;
  fe_pkg::addr_t      pc;
  fe_pkg::slot_mask_t mask;

  modport src (output valid, pc, mask, input ready);
  modport dst (input valid, pc, mask, output ready);
endinterface

// raw words from fetch to decoder
interface fe_inst_if;
  logic                    valid;
  logic                    ready;
  fe_pkg::addr_t           pc;
  fe_pkg::slot_mask_t      mask;
  fe_pkg::inst_t [1:0]     inst;

  modport src (output valid, pc, mask, inst, input ready);
  modport dst (input valid, pc, mask, inst, output ready);
endinterface

// decoded pairs
interface fe_pair_if;
  logic          valid;
  logic          ready;
  fe_pkg::pair_t pair;

  modport src (output valid, pair, input ready);
  modport dst (input valid, pair, output ready);
endinterface

`default_nettype wire

//--- rtl/fe_pcgen.sv
`timescale 1ns/1ps
`default_nettype none

module fe_pcgen (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          redirect_i,
  input  fe_pkg::addr_t redirect_pc_i,
  fe_pc_if.src          pc_o
);

  logic               valid_q;
  fe_pkg::addr_t      pc_q;
  fe_pkg::slot_mask_t mask_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_q <= 1'b0;
      pc_q    <= '0;
      mask_q  <= 2'b11;
    end
    else if (redirect_i)
    begin
      valid_q <= 1'b1;
      pc_q    <= {redirect_pc_i[31:3], 3'b000};
      // landing on the upper word drops slot 0
      mask_q  <= redirect_pc_i[2] ? 2'b10 : 2'b11;
    end
    else
    begin
      valid_q <= 1'b1;
      if (pc_o.valid && pc_o.ready)
      begin
        pc_q   <= pc_q + fe_pkg::addr_t'(8);
        mask_q <= 2'b11;
      end
    end
  end

  assign pc_o.valid = valid_q;
  assign pc_o.pc    = pc_q;
  assign pc_o.mask  = mask_q;

  // fetch pairs are always whole 8-byte blocks
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc_o.valid |-> (pc_o.pc[2:0] == 3'b000)
  );

endmodule

`default_nettype wire

//--- rtl/fe_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fe_fetch (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          redirect_i,
  fe_pc_if.dst          pc_i,
  output logic          imem_req_o,
  output fe_pkg::addr_t imem_addr_o,
  input  logic [63:0]   imem_rdata_i,
  fe_inst_if.src        inst_o
);

  // in-flight request record
  logic               req_q;
  fe_pkg::addr_t      req_pc_q;
  fe_pkg::slot_mask_t req_mask_q;

  // two-entry response buffer
  fe_pkg::addr_t       buf_pc   [fe_pkg::FETCH_CREDITS];
  fe_pkg::slot_mask_t  buf_mask [fe_pkg::FETCH_CREDITS];
  fe_pkg::inst_t [1:0] buf_inst [fe_pkg::FETCH_CREDITS];
  logic                wr_ptr_q;
  logic                rd_ptr_q;
  logic [1:0]          cnt_q;

  logic [1:0] credits;
  logic       push;
  logic       pop;

  assign credits    = {1'b0, req_q} + cnt_q;
  assign pc_i.ready = !redirect_i && (credits < 2'(fe_pkg::FETCH_CREDITS));
  assign imem_req_o  = pc_i.valid && pc_i.ready;
  assign imem_addr_o = pc_i.pc;

  // responses to requests made before a redirect are dropped
  assign push = req_q && !redirect_i;
  assign pop  = inst_o.valid && inst_o.ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n || redirect_i)
    begin
      req_q    <= 1'b0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= '0;
    end
    else
    begin
      req_q <= imem_req_o;
      if (push)
      begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop)
      begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      cnt_q <= cnt_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk)
  begin
    if (imem_req_o)
    begin
      req_pc_q   <= pc_i.pc;
      req_mask_q <= pc_i.mask;
    end
    if (push)
    begin
      buf_pc[wr_ptr_q]   <= req_pc_q;
      buf_mask[wr_ptr_q] <= req_mask_q;
      buf_inst[wr_ptr_q] <= imem_rdata_i;
    end
  end

  assign inst_o.valid = (cnt_q != '0);

  always_comb
  begin
    inst_o.pc   = buf_pc[rd_ptr_q];
    inst_o.mask = buf_mask[rd_ptr_q];
    inst_o.inst = buf_inst[rd_ptr_q];
    // only the upper word is valid so it moves down to slot 0
    if (!buf_mask[rd_ptr_q][0])
    begin
      inst_o.pc[2]   = 1'b1;
      inst_o.mask    = {1'b0, buf_mask[rd_ptr_q][1]};
      inst_o.inst[0] = buf_inst[rd_ptr_q][1];
    end
  end

  a_credit_limit: assert property (
    @(posedge clk) disable iff (!rst_n)
    credits <= 2'(fe_pkg::FETCH_CREDITS)
  );

endmodule

`default_nettype wire

//--- rtl/fe_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module fe_decoder (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   redirect_i,
  fe_inst_if.dst inst_i,
  fe_pair_if.src pair_o
);

  function automatic fe_pkg::slot_t decode_slot(
    input fe_pkg::inst_t inst,
    input fe_pkg::addr_t pc
  );
    fe_pkg::slot_t   s;
    fe_pkg::r0_sel_e r0_sel;
    fe_pkg::r1_sel_e r1_sel;
    fe_pkg::w_sel_e  w_sel;
    s.pc   = pc;
    s.op   = fe_pkg::OP_INVALID;
    r0_sel = fe_pkg::R0_NONE;
    r1_sel = fe_pkg::R1_NONE;
    w_sel  = fe_pkg::W_NONE;
    if (inst[31:15] == fe_pkg::OPC_ADD_W || inst[31:15] == fe_pkg::OPC_SUB_W ||
        inst[31:15] == fe_pkg::OPC_AND   || inst[31:15] == fe_pkg::OPC_OR)
    begin
      s.op   = fe_pkg::OP_ALU3R;
      r0_sel = fe_pkg::R0_RK;
      r1_sel = fe_pkg::R1_RJ;
      w_sel  = fe_pkg::W_RD;
    end
    else if (inst[31:22] == fe_pkg::OPC_ADDI_W || inst[31:22] == fe_pkg::OPC_ORI)
    begin
      s.op   = fe_pkg::OP_ALU2RI;
      r1_sel = fe_pkg::R1_RJ;
      w_sel  = fe_pkg::W_RD;
    end
    else if (inst[31:25] == fe_pkg::OPC_LU12I_W)
    begin
      s.op  = fe_pkg::OP_LU12I;
      w_sel = fe_pkg::W_RD;
    end
    else if (inst[31:22] == fe_pkg::OPC_LD_W)
    begin
      s.op   = fe_pkg::OP_LOAD;
      r1_sel = fe_pkg::R1_RJ;
      w_sel  = fe_pkg::W_RD;
    end
    else if (inst[31:22] == fe_pkg::OPC_ST_W)
    begin
      s.op   = fe_pkg::OP_STORE;
      r0_sel = fe_pkg::R0_RD;
      r1_sel = fe_pkg::R1_RJ;
    end
    else if (inst[31:26] == fe_pkg::OPC_BEQ || inst[31:26] == fe_pkg::OPC_BNE)
    begin
      s.op   = fe_pkg::OP_BRANCH;
      r0_sel = fe_pkg::R0_RD;
      r1_sel = fe_pkg::R1_RJ;
    end
    else if (inst[31:26] == fe_pkg::OPC_JIRL)
    begin
      s.op   = fe_pkg::OP_JIRL;
      r1_sel = fe_pkg::R1_RJ;
      w_sel  = fe_pkg::W_RD;
    end
    else if (inst[31:26] == fe_pkg::OPC_BL)
    begin
      s.op  = fe_pkg::OP_BL;
      w_sel = fe_pkg::W_BL1;
    end
    // register fields from the selects and zero when unused
    case (r0_sel)
      fe_pkg::R0_RK: s.ri.rs0 = inst[14:10];
      fe_pkg::R0_RD: s.ri.rs0 = inst[4:0];
      default:       s.ri.rs0 = '0;
    endcase
    s.ri.rs1 = (r1_sel == fe_pkg::R1_RJ) ? inst[9:5] : '0;
    case (w_sel)
      fe_pkg::W_RD:  s.ri.rd = inst[4:0];
      fe_pkg::W_BL1: s.ri.rd = 5'd1;
      default:       s.ri.rd = '0;
    endcase
    s.ine = (s.op == fe_pkg::OP_INVALID);
    return s;
  endfunction

  fe_pkg::pair_t dec_pair;
  fe_pkg::pair_t pair_q;
  logic          valid_q;

  always_comb
  begin
    dec_pair.mask = inst_i.mask;
    for (int i = 0; i < 2; i++)
    begin
      dec_pair.slot[i] = decode_slot(inst_i.inst[i], inst_i.pc + fe_pkg::addr_t'(4 * i));
    end
  end

  // one-entry pipe register
  assign inst_i.ready = !valid_q || pair_o.ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n || redirect_i)
    begin
      valid_q <= 1'b0;
    end
    else if (inst_i.ready)
    begin
      valid_q <= inst_i.valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (inst_i.valid && inst_i.ready)
    begin
      pair_q <= dec_pair;
    end
  end

  assign pair_o.valid = valid_q;
  assign pair_o.pair  = pair_q;

endmodule

`default_nettype wire

//--- rtl/fe_pkg_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fe_pkg_fifo (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   redirect_i,
  fe_pair_if.dst in_i,
  fe_pair_if.src out_o
);

  fe_pkg::pair_t     mem [fe_pkg::FIFO_DEPTH];
  fe_pkg::fifo_ptr_t wr_ptr_q;
  fe_pkg::fifo_ptr_t rd_ptr_q;
  fe_pkg::fifo_cnt_t count_q;
  logic              push;
  logic              pop;

  assign in_i.ready  = (count_q < fe_pkg::fifo_cnt_t'(fe_pkg::FIFO_DEPTH));
  assign out_o.valid = (count_q != '0);
  assign out_o.pair  = mem[rd_ptr_q];

  assign push = in_i.valid && in_i.ready;
  assign pop  = out_o.valid && out_o.ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n || redirect_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      // depth is a power of two so the pointers wrap on their own
      if (push)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + fe_pkg::fifo_cnt_t'(push) - fe_pkg::fifo_cnt_t'(pop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr_q] <= in_i.pair;
    end
  end

  // a write when full or a read when empty moves the count out of range
  a_no_write_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_q <= fe_pkg::fifo_cnt_t'(fe_pkg::FIFO_DEPTH)
  );

  // pointer distance tracks the count
  a_no_read_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wr_ptr_q - rd_ptr_q) == fe_pkg::fifo_ptr_t'(count_q)
  );

endmodule

`default_nettype wire

//--- rtl/fe_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module fe_frontend (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     redirect_i,
  input  fe_pkg::addr_t            redirect_pc_i,
  output logic                     imem_req_o,
  output fe_pkg::addr_t            imem_addr_o,
  input  logic [63:0]              imem_rdata_i,
  output logic                     pkg_valid_o,
  input  logic                     pkg_ready_i,
  output fe_pkg::slot_mask_t       pkg_mask_o,
  output fe_pkg::addr_t     [1:0]  pkg_pc_o,
  output fe_pkg::op_class_e [1:0]  pkg_op_o,
  output fe_pkg::reg_idx_t  [1:0]  pkg_rs0_o,
  output fe_pkg::reg_idx_t  [1:0]  pkg_rs1_o,
  output fe_pkg::reg_idx_t  [1:0]  pkg_rd_o,
  output logic [1:0]               pkg_ine_o
);

  fe_pc_if   pc_if ();
  fe_inst_if inst_if ();
  fe_pair_if pair_if ();
  fe_pair_if pkg_if ();

  fe_pcgen i_pcgen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc_if.src)
  );

  fe_fetch i_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect_i),
    .pc_i         (pc_if.dst),
    .imem_req_o   (imem_req_o),
    .imem_addr_o  (imem_addr_o),
    .imem_rdata_i (imem_rdata_i),
    .inst_o       (inst_if.src)
  );

  fe_decoder i_decoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect_i),
    .inst_i     (inst_if.dst),
    .pair_o     (pair_if.src)
  );

  fe_pkg_fifo i_pkg_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect_i),
    .in_i       (pair_if.dst),
    .out_o      (pkg_if.src)
  );

  // back end sees the fifo head directly
  assign pkg_valid_o  = pkg_if.valid;
  assign pkg_if.ready = pkg_ready_i;
  assign pkg_mask_o   = pkg_if.pair.mask;

  for (genvar i = 0; i < 2; i++)
  begin : gen_flat
    assign pkg_pc_o[i]  = pkg_if.pair.slot[i].pc;
    assign pkg_op_o[i]  = pkg_if.pair.slot[i].op;
    assign pkg_rs0_o[i] = pkg_if.pair.slot[i].ri.rs0;
    assign pkg_rs1_o[i] = pkg_if.pair.slot[i].ri.rs1;
    assign pkg_rd_o[i]  = pkg_if.pair.slot[i].ri.rd;
    assign pkg_ine_o[i] = pkg_if.pair.slot[i].ine;
  end

endmodule

`default_nettype wire

//--- testbench/tb_frontend_model.svh
`ifndef TB_FRONTEND_MODEL_SVH
`define TB_FRONTEND_MODEL_SVH

// memory image with the class picked from address bits and fields hashed from the address
function automatic fe_pkg::inst_t image_word(input fe_pkg::addr_t a);
  logic [31:0] h;
  logic [3:0]  sel;
  h   = (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  sel = a[5:2] ^ a[9:6] ^ a[13:10];
  case (sel)
    4'd0, 4'd1: image_word = {6'h3f, h[25:0]};
    4'd2:       image_word = {17'h0_0020, h[14:0]};
    4'd3:       image_word = {17'h0_0022, h[14:0]};
    4'd4:       image_word = {17'h0_0029, h[14:0]};
    4'd5:       image_word = {17'h0_002a, h[14:0]};
    4'd6:       image_word = {10'h00a, h[21:0]};
    4'd7:       image_word = {10'h00e, h[21:0]};
    4'd8:       image_word = {7'h0a, h[24:0]};
    4'd9:       image_word = {10'h0a2, h[21:0]};
    4'd10:      image_word = {10'h0a6, h[21:0]};
    4'd11:      image_word = {6'h13, h[25:0]};
    4'd12:      image_word = {6'h15, h[25:0]};
    4'd13:      image_word = {6'h16, h[25:0]};
    default:    image_word = {6'h17, h[25:0]};
  endcase
endfunction

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

function automatic fe_pkg::slot_t ref_decode(input fe_pkg::inst_t w, input fe_pkg::addr_t pc);
  fe_pkg::slot_t e;
  logic [31:0]   m17;
  logic [31:0]   m10;
  logic [31:0]   m7;
  logic [31:0]   m6;
  logic          src_rj;
  logic          wr_rd;
  e    = '0;
  e.pc = pc;
  m17  = w & 32'hffff_8000;
  m10  = w & 32'hffc0_0000;
  m7   = w & 32'hfe00_0000;
  m6   = w & 32'hfc00_0000;
  if (m17 == 32'h0010_0000 || m17 == 32'h0011_0000 ||
      m17 == 32'h0014_8000 || m17 == 32'h0015_0000)
    e.op = fe_pkg::OP_ALU3R;
  else if (m10 == 32'h0280_0000 || m10 == 32'h0380_0000)
    e.op = fe_pkg::OP_ALU2RI;
  else if (m7 == 32'h1400_0000)
    e.op = fe_pkg::OP_LU12I;
  else if (m10 == 32'h2880_0000)
    e.op = fe_pkg::OP_LOAD;
  else if (m10 == 32'h2980_0000)
    e.op = fe_pkg::OP_STORE;
  else if (m6 == 32'h5800_0000 || m6 == 32'h5c00_0000)
    e.op = fe_pkg::OP_BRANCH;
  else if (m6 == 32'h4c00_0000)
    e.op = fe_pkg::OP_JIRL;
  else if (m6 == 32'h5400_0000)
    e.op = fe_pkg::OP_BL;
  else
    e.op = fe_pkg::OP_INVALID;
  src_rj = e.op == fe_pkg::OP_ALU3R || e.op == fe_pkg::OP_ALU2RI || e.op == fe_pkg::OP_LOAD ||
           e.op == fe_pkg::OP_JIRL || e.op == fe_pkg::OP_STORE || e.op == fe_pkg::OP_BRANCH;
  wr_rd  = e.op == fe_pkg::OP_ALU3R || e.op == fe_pkg::OP_ALU2RI || e.op == fe_pkg::OP_LOAD ||
           e.op == fe_pkg::OP_JIRL || e.op == fe_pkg::OP_LU12I;
  if (e.op == fe_pkg::OP_ALU3R)
    e.ri.rs0 = w[14:10];
  else if (e.op == fe_pkg::OP_STORE || e.op == fe_pkg::OP_BRANCH)
    e.ri.rs0 = w[4:0];
  if (src_rj)
    e.ri.rs1 = w[9:5];
  if (wr_rd)
    e.ri.rd = w[4:0];
  else if (e.op == fe_pkg::OP_BL)
    e.ri.rd = 5'd1;
  e.ine = (e.op == fe_pkg::OP_INVALID);
  return e;
endfunction

`endif

//--- testbench/tb_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     redirect_i;
  fe_pkg::addr_t            redirect_pc_i;
  logic                     imem_req_o;
  fe_pkg::addr_t            imem_addr_o;
  logic [63:0]              imem_rdata_i = '1;
  logic                     pkg_valid_o;
  logic                     pkg_ready_i;
  fe_pkg::slot_mask_t       pkg_mask_o;
  fe_pkg::addr_t     [1:0]  pkg_pc_o;
  fe_pkg::op_class_e [1:0]  pkg_op_o;
  fe_pkg::reg_idx_t  [1:0]  pkg_rs0_o;
  fe_pkg::reg_idx_t  [1:0]  pkg_rs1_o;
  fe_pkg::reg_idx_t  [1:0]  pkg_rd_o;
  logic [1:0]               pkg_ine_o;

  logic [31:0]   lfsr_q = 32'hbe51_97cb;
  int            ready_mode = 0;
  fe_pkg::addr_t exp_pc = '0;
  fe_pkg::addr_t last_target = '0;
  int            accepted = 0;
  int            checks = 0;
  int            errors = 0;
  int            timeouts = 0;
  logic          pending = 1'b0;
  int            wait_cnt = 0;

  `include "tb_frontend_model.svh"

  fe_frontend i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_rdata_i  (imem_rdata_i),
    .pkg_valid_o   (pkg_valid_o),
    .pkg_ready_i   (pkg_ready_i),
    .pkg_mask_o    (pkg_mask_o),
    .pkg_pc_o      (pkg_pc_o),
    .pkg_op_o      (pkg_op_o),
    .pkg_rs0_o     (pkg_rs0_o),
    .pkg_rs1_o     (pkg_rs1_o),
    .pkg_rd_o      (pkg_rd_o),
    .pkg_ine_o     (pkg_ine_o)
  );

  always #10 clk = ~clk;

  task automatic finish_run();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // one clock and then the next cycle's inputs
  task automatic step_cycle();
    logic [31:0] bits;
    @(posedge clk);
    #1;
    redirect_i = 1'b0;
    if (ready_mode == 0)
      pkg_ready_i = 1'b1;
    else
    begin
      take_bits(ready_mode, bits);
      pkg_ready_i = |bits;
    end
  endtask

  task automatic wait_packages(input int n);
    int target;
    int cycles;
    target = accepted + n;
    cycles = 0;
    while (timeouts == 0 && accepted < target && cycles < 50 * n + 200)
    begin
      step_cycle();
      cycles++;
    end
    if (timeouts == 0 && accepted < target)
    begin
      $display("timeout: only %0d of %0d packages accepted", accepted - target + n, n);
      timeouts++;
    end
  endtask

  task automatic do_redirect(input fe_pkg::addr_t target);
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    step_cycle();
  endtask

  // memory with one cycle of read latency
  always @(posedge clk)
  begin
    fe_pkg::addr_t a;
    logic          req;
    a   = imem_addr_o;
    req = imem_req_o;
    if (req && a[2:0] != 3'b000)
    begin
      errors++;
      $display("error @%0t: unaligned fetch address %h", $time, a);
    end
    #1;
    imem_rdata_i = req ? {image_word(a + 32'd4), image_word(a)} : '1;
  end

  task automatic check_package();
    fe_pkg::slot_t      e;
    fe_pkg::slot_mask_t exp_mask;
    fe_pkg::addr_t      pc;
    int                 n;
    int                 i;
    exp_mask = exp_pc[2] ? 2'b01 : 2'b11;
    n        = exp_pc[2] ? 1 : 2;
    checks++;
    if (pkg_mask_o !== exp_mask)
    begin
      errors++;
      $display("error @%0t: mask %b, expected %b at pc %h", $time, pkg_mask_o, exp_mask, exp_pc);
    end
    for (i = 0; i < n; i++)
    begin
      pc = exp_pc + 32'(4 * i);
      e  = ref_decode(image_word(pc), pc);
      if (pkg_pc_o[i] !== e.pc)
      begin
        errors++;
        $display("error @%0t: slot %0d pc %h, expected %h", $time, i, pkg_pc_o[i], e.pc);
      end
      if (pkg_op_o[i] !== e.op || pkg_rs0_o[i] !== e.ri.rs0 || pkg_rs1_o[i] !== e.ri.rs1 ||
          pkg_rd_o[i] !== e.ri.rd || pkg_ine_o[i] !== e.ine)
      begin
        errors++;
        // fields in the order op rs0 rs1 rd ine
        $display("error @%0t: pc %h got %0d %0d %0d %0d %b, expected %0d %0d %0d %0d %b",
                 $time, pc, pkg_op_o[i], pkg_rs0_o[i], pkg_rs1_o[i], pkg_rd_o[i], pkg_ine_o[i],
                 e.op, e.ri.rs0, e.ri.rs1, e.ri.rd, e.ine);
      end
    end
    exp_pc = exp_pc + 32'(4 * n);
    accepted++;
  endtask

  // compares every accepted package with the expected stream
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (pkg_valid_o && pkg_ready_i)
        check_package();
      if (redirect_i)
      begin
        exp_pc      = redirect_pc_i;
        last_target = redirect_pc_i;
        pending     = 1'b1;
        wait_cnt    = 0;
      end
      else if (pending && pkg_valid_o)
        pending = 1'b0;
      else if (pending)
      begin
        wait_cnt++;
        if (wait_cnt > 200)
        begin
          $display("timeout: no package within 200 cycles of redirect to %h", last_target);
          timeouts++;
          pending = 1'b0;
        end
      end
    end
  end

  initial
  begin
    logic [31:0] bits;
    int          r;
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    pkg_ready_i   = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n       = 1'b1;
    pkg_ready_i = 1'b1;
    checks++;
    if (imem_req_o !== 1'b0 || pkg_valid_o !== 1'b0)
    begin
      errors++;
      $display("error @%0t: imem_req_o %b pkg_valid_o %b after reset", $time, imem_req_o,
               pkg_valid_o);
    end
    wait_packages(24);
    ready_mode = 1;
    wait_packages(40);
    // land on the upper word of a pair
    ready_mode = 2;
    do_redirect(32'h0000_1234);
    wait_packages(12);
    for (r = 0; r < 40 && timeouts == 0; r++)
    begin
      ready_mode = (r % 2) + 1;
      take_bits(14, bits);
      do_redirect({16'h0000, bits[13:0], 2'b00});
      take_bits(3, bits);
      wait_packages(int'(bits[2:0]));
    end
    wait_packages(16);
    finish_run();
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+testbench
rtl/fe_pkg.sv
rtl/fe_if.sv
rtl/fe_pcgen.sv
rtl/fe_fetch.sv
rtl/fe_decoder.sv
rtl/fe_pkg_fifo.sv
rtl/fe_frontend.sv
testbench/tb_frontend.sv
